/* rtl/cachePkg.sv */
package cachePkg;

  // address split, msb first: tag | index | offset
  localparam int ADDR_W   = 32;
  localparam int XLEN     = 64;
  localparam int TAG_W    = 21;
  localparam int INDEX_W  = 6;
  localparam int OFFSET_W = 5;

  // geometry of one way
  localparam int SETS   = 1 << INDEX_W;
  localparam int BEATS  = 4;
  localparam int LINE_W = BEATS * XLEN;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [XLEN-1:0]   word_t;

  // word 0 sits in the low bits
  typedef logic [LINE_W-1:0] line_t;

  // tag array entry, valid bits live in the way-state table
  typedef logic [TAG_W-1:0]  tagEntry_t;

  // line request towards the bus master
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } memReq_t;

  // one returned beat, last marks the fourth
  typedef struct packed {
    logic  valid;
    logic  last;
    word_t data;
  } memResp_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    COMPARE = 3'd1,
    MISS    = 3'd2,
    REFILL  = 3'd3,
    FILL    = 3'd4
  } state_t;

endpackage

/* rtl/cacheSram.sv */
`timescale 1ns/10ps
module cacheSram #(
  parameter type entry_t = logic,
  parameter int  DEPTH   = 64
) (
  input  logic                         clk,
  input  logic                         en_i,
  input  logic                         we_i,
  input  logic [cachePkg::INDEX_W-1:0] addr_i,
  input  entry_t                       wdata_i,
  output entry_t                       rdata_o
);

  entry_t mem [DEPTH];

  // single port, registered read
  // a write also returns the written entry on rdata_o
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
        rdata_o     <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

/* rtl/refillBuffer.sv */
`timescale 1ns/10ps
module refillBuffer (
  input  logic               clk,
  input  logic               rst_n,
  input  cachePkg::memResp_t memResp_i,
  output cachePkg::line_t    line_o,
  output logic               lineReady_o
);
  import cachePkg::*;

  // slot for the next beat
  logic [$clog2(BEATS)-1:0] beatCnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt     <= '0;
      lineReady_o <= 1'b0;
    end else begin
      // one-cycle pulse after the last beat
      lineReady_o <= memResp_i.valid && memResp_i.last;
      if (memResp_i.valid) begin
        if (memResp_i.last) begin
          beatCnt <= '0;
        end else begin
          beatCnt <= beatCnt + 1'b1;
        end
      end
    end
  end

  // beats come in word order, gaps allowed
  always_ff @(posedge clk) begin
    if (memResp_i.valid) begin
      line_o[beatCnt*XLEN +: XLEN] <= memResp_i.data;
    end
  end

endmodule

/* rtl/wayStateTable.sv */
`timescale 1ns/10ps
module wayStateTable (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [cachePkg::INDEX_W-1:0] index_i,
  input  logic                         fill_i,
  input  logic                         touch_i,
  input  logic                         way_i,
  output logic [1:0]                   valid_o,
  output logic                         victim_o
);
  import cachePkg::*;

  logic [SETS-1:0] valid0;
  logic [SETS-1:0] valid1;
  // lru bit names the way to replace next
  logic [SETS-1:0] lru;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid0 <= '0;
      valid1 <= '0;
      lru    <= '0;
    end else begin
      if (fill_i) begin
        if (way_i) begin
          valid1[index_i] <= 1'b1;
        end else begin
          valid0[index_i] <= 1'b1;
        end
      end
      // most recent use points lru at the other way
      if (fill_i || touch_i) begin
        lru[index_i] <= ~way_i;
      end
    end
  end

  assign valid_o = {valid1[index_i], valid0[index_i]};

  // empty way first, way 0 before way 1
  assign victim_o = !valid0[index_i] ? 1'b0 :
                    !valid1[index_i] ? 1'b1 : lru[index_i];

endmodule

/* rtl/cacheCtrl.sv */
`timescale 1ns/10ps
module cacheCtrl (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         valid_i,
  input  cachePkg::addr_t              addr_i,
  output logic                         addrOk_o,
  output logic                         dataOk_o,
  output cachePkg::word_t              rdData_o,
  output cachePkg::memReq_t            memReq_o,
  input  cachePkg::tagEntry_t          tag0_i,
  input  cachePkg::tagEntry_t          tag1_i,
  input  cachePkg::line_t              line0_i,
  input  cachePkg::line_t              line1_i,
  output logic                         sramEn_o,
  output logic [cachePkg::INDEX_W-1:0] sramIndex_o,
  output logic [1:0]                   tagWe_o,
  output logic [1:0]                   lineWe_o,
  output cachePkg::tagEntry_t          fillTag_o,
  output cachePkg::line_t              fillLine_o,
  input  cachePkg::line_t              refillLine_i,
  input  logic                         lineReady_i,
  input  logic [1:0]                   wayValid_i,
  input  logic                         victim_i,
  output logic [cachePkg::INDEX_W-1:0] stIndex_o,
  output logic                         fill_o,
  output logic                         touch_o,
  output logic                         way_o
);
  import cachePkg::*;

  state_t                   curState;
  state_t                   nextState;
  addr_t                    reqAddr;
  tagEntry_t                reqTag;
  logic [INDEX_W-1:0]       reqIndex;
  logic [$clog2(BEATS)-1:0] wordSel;
  logic                     accept;
  logic                     hit0;
  logic                     hit1;
  logic                     hit;
  logic                     fillNow;
  line_t                    hitLine;

  assign reqTag   = reqAddr[ADDR_W-1 -: TAG_W];
  assign reqIndex = reqAddr[OFFSET_W +: INDEX_W];
  // offset bits 4:3 pick the 64-bit word
  assign wordSel  = reqAddr[OFFSET_W-1 -: $clog2(BEATS)];

  // tag compare against the arrays read last cycle
  assign hit0 = wayValid_i[0] && (tag0_i == reqTag);
  assign hit1 = wayValid_i[1] && (tag1_i == reqTag);
  assign hit  = hit0 || hit1;

  assign addrOk_o = (curState == IDLE) || ((curState == COMPARE) && hit);
  assign accept   = valid_i && addrOk_o;
  assign dataOk_o = (curState == COMPARE) && hit;
  assign fillNow  = (curState == FILL);

  assign hitLine  = hit1 ? line1_i : line0_i;
  assign rdData_o = hitLine[wordSel*XLEN +: XLEN];

  // line request, offset forced to zero
  assign memReq_o.valid = (curState == MISS);
  assign memReq_o.addr  = {reqAddr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  // new lookup on accept, write on fill
  // non-victim arrays read the same set during fill
  assign sramEn_o    = accept || fillNow;
  assign sramIndex_o = accept ? addr_i[OFFSET_W +: INDEX_W] : reqIndex;
  assign tagWe_o     = fillNow ? {victim_i, ~victim_i} : 2'b00;
  assign lineWe_o    = fillNow ? {victim_i, ~victim_i} : 2'b00;
  assign fillTag_o   = reqTag;
  assign fillLine_o  = refillLine_i;

  assign stIndex_o = reqIndex;
  assign fill_o    = fillNow;
  assign touch_o   = dataOk_o;
  assign way_o     = fillNow ? victim_i : hit1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curState <= IDLE;
    end else begin
      curState <= nextState;
    end
  end

  always_comb begin
    nextState = curState;
    case (curState)
      IDLE: begin
        if (accept) begin
          nextState = COMPARE;
        end
      end
      COMPARE: begin
        if (!hit) begin
          nextState = MISS;
        end else if (!valid_i) begin
          nextState = IDLE;
        end
      end
      MISS:    nextState = REFILL;
      REFILL: begin
        if (lineReady_i) begin
          nextState = FILL;
        end
      end
      // replay the lookup on the freshly written set
      FILL:    nextState = COMPARE;
      default: nextState = IDLE;
    endcase
  end

  // request latch
  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= addr_i;
    end
  end

endmodule

/* rtl/icacheTop.sv */
`timescale 1ns/10ps
module icacheTop (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               valid_i,
  input  cachePkg::addr_t    addr_i,
  output logic               addrOk_o,
  output logic               dataOk_o,
  output cachePkg::word_t    rdData_o,
  output cachePkg::memReq_t  memReq_o,
  input  cachePkg::memResp_t memResp_i
);
  import cachePkg::*;

  logic               sramEn;
  logic [INDEX_W-1:0] sramIndex;
  logic [1:0]         tagWe;
  logic [1:0]         lineWe;
  tagEntry_t          fillTag;
  line_t              fillLine;
  tagEntry_t          tag0;
  tagEntry_t          tag1;
  line_t              line0;
  line_t              line1;
  line_t              refillLine;
  logic               lineReady;
  logic [1:0]         wayValid;
  logic               victim;
  logic [INDEX_W-1:0] stIndex;
  logic               fill;
  logic               touch;
  logic               way;

  cacheCtrl uCtrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid_i),
    .addr_i       (addr_i),
    .addrOk_o     (addrOk_o),
    .dataOk_o     (dataOk_o),
    .rdData_o     (rdData_o),
    .memReq_o     (memReq_o),
    .tag0_i       (tag0),
    .tag1_i       (tag1),
    .line0_i      (line0),
    .line1_i      (line1),
    .sramEn_o     (sramEn),
    .sramIndex_o  (sramIndex),
    .tagWe_o      (tagWe),
    .lineWe_o     (lineWe),
    .fillTag_o    (fillTag),
    .fillLine_o   (fillLine),
    .refillLine_i (refillLine),
    .lineReady_i  (lineReady),
    .wayValid_i   (wayValid),
    .victim_i     (victim),
    .stIndex_o    (stIndex),
    .fill_o       (fill),
    .touch_o      (touch),
    .way_o        (way)
  );

  // tag arrays, one per way
  cacheSram #(.entry_t(tagEntry_t), .DEPTH(SETS)) uTag0 (
    .clk (clk), .en_i (sramEn), .we_i (tagWe[0]), .addr_i (sramIndex),
    .wdata_i (fillTag), .rdata_o (tag0)
  );
  cacheSram #(.entry_t(tagEntry_t), .DEPTH(SETS)) uTag1 (
    .clk (clk), .en_i (sramEn), .we_i (tagWe[1]), .addr_i (sramIndex),
    .wdata_i (fillTag), .rdata_o (tag1)
  );

  // data arrays, a whole line per entry
  cacheSram #(.entry_t(line_t), .DEPTH(SETS)) uData0 (
    .clk (clk), .en_i (sramEn), .we_i (lineWe[0]), .addr_i (sramIndex),
    .wdata_i (fillLine), .rdata_o (line0)
  );
  cacheSram #(.entry_t(line_t), .DEPTH(SETS)) uData1 (
    .clk (clk), .en_i (sramEn), .we_i (lineWe[1]), .addr_i (sramIndex),
    .wdata_i (fillLine), .rdata_o (line1)
  );

  refillBuffer uRefill (
    .clk         (clk),
    .rst_n       (rst_n),
    .memResp_i   (memResp_i),
    .line_o      (refillLine),
    .lineReady_o (lineReady)
  );

  wayStateTable uWayState (
    .clk      (clk),
    .rst_n    (rst_n),
    .index_i  (stIndex),
    .fill_i   (fill),
    .touch_i  (touch),
    .way_i    (way),
    .valid_o  (wayValid),
    .victim_o (victim)
  );

endmodule

/* test/refillMem.sv */
`timescale 1ns/10ps
module refillMem (
  input  logic               clk,
  input  logic               rst_n,
  input  cachePkg::memReq_t  memReq_i,
  input  logic [1:0]         gap_i,
  output cachePkg::memResp_t memResp_o
);
  import cachePkg::*;

  logic       busy;
  addr_t      lineAddr;
  addr_t      wordAddr;
  logic [1:0] beat;
  logic [1:0] waitCnt;

  // byte address of the beat being returned
  assign wordAddr = lineAddr + {27'd0, beat, 3'b000};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      lineAddr  <= '0;
      beat      <= '0;
      waitCnt   <= '0;
      memResp_o <= '0;
    end else begin
      memResp_o.valid <= 1'b0;
      memResp_o.last  <= 1'b0;
      if (memReq_i.valid && !busy) begin
        busy     <= 1'b1;
        lineAddr <= memReq_i.addr;
        beat     <= '0;
        waitCnt  <= gap_i;
      end else if (busy) begin
        if (waitCnt != 2'd0) begin
          waitCnt <= waitCnt - 2'd1;
        end else begin
          // upper half inverted address, lower half address
          memResp_o.valid <= 1'b1;
          memResp_o.last  <= (beat == 2'd3);
          memResp_o.data  <= {~wordAddr, wordAddr};
          beat            <= beat + 2'd1;
          waitCnt         <= gap_i;
          if (beat == 2'd3) begin
            busy <= 1'b0;
          end
        end
      end
    end
  end

endmodule

/* test/cacheCtrl_props.sv */
`timescale 1ns/10ps
module cacheCtrl_props (
  input logic              clk,
  input logic              rst_n,
  input logic              valid_i,
  input logic              addrOk_o,
  input logic              dataOk_o,
  input logic              hit,
  input cachePkg::state_t  curState,
  input cachePkg::memReq_t memReq_o
);
  import cachePkg::*;

  // accepted requests still waiting for dataOk
  int outstanding;
  // a line request stays open until its answer
  logic missOpen;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 0;
      missOpen    <= 1'b0;
    end else begin
      outstanding <= outstanding + int'(valid_i && addrOk_o) - int'(dataOk_o);
      if (memReq_o.valid) begin
        missOpen <= 1'b1;
      end else if (dataOk_o) begin
        missOpen <= 1'b0;
      end
    end
  end

  reqAfterMiss: assert property (@(posedge clk) disable iff (!rst_n)
    memReq_o.valid |-> $past((curState == COMPARE) && !hit))
    else $error("line request without a missing compare before it");

  answerHasRequest: assert property (@(posedge clk) disable iff (!rst_n)
    dataOk_o |-> (outstanding > 0))
    else $error("dataOk without an accepted request");

  // only the missing request may be open at a line request
  singleOpenAtReq: assert property (@(posedge clk) disable iff (!rst_n)
    memReq_o.valid |-> (outstanding == 1))
    else $error("line request while earlier requests are unanswered");

  // from the line request up to the replayed answer
  noAcceptInMiss: assert property (@(posedge clk) disable iff (!rst_n)
    (memReq_o.valid || (missOpen && !dataOk_o)) |-> !addrOk_o)
    else $error("addrOk high during miss handling");

endmodule

bind cacheCtrl cacheCtrl_props uProps (
  .clk      (clk),
  .rst_n    (rst_n),
  .valid_i  (valid_i),
  .addrOk_o (addrOk_o),
  .dataOk_o (dataOk_o),
  .hit      (hit),
  .curState (curState),
  .memReq_o (memReq_o)
);

/* test/cacheTb.sv */
`timescale 1ns/10ps
module cacheTb;
  import cachePkg::*;

  localparam int RAND_REQ    = 80;
  // directed requests plus the random mix
  localparam int NUM_REQ     = 18 + RAND_REQ;
  localparam int MISS_LAT    = 32;
  localparam int CYCLE_LIMIT = 16 + NUM_REQ * MISS_LAT + 400;

  logic      clk;
  logic      rst_n;
  logic      valid_i;
  addr_t     addr_i;
  logic      addrOk;
  logic      dataOk;
  word_t     rdData;
  memReq_t   memReq;
  memResp_t  memResp;
  logic [1:0] gap;

  int          cycle = 0;
  logic [15:0] addrLfsr = 16'd87;
  logic [15:0] gapLfsr = 16'd87;
  string       testName = "reset";

  // scoreboard of accepted requests
  addr_t pending[$];
  logic  predHit[$];
  int    acceptAt[$];
  int    reqSeen = 0;
  logic  lastPredHit;
  // the last answered request needed a line request
  logic  lastMissed;

  // reference copy of the way state
  tagEntry_t tagRef [SETS][2];
  logic [1:0] vldRef [SETS];
  logic       lruRef [SETS];

  icacheTop DUT (
    .clk (clk), .rst_n (rst_n), .valid_i (valid_i), .addr_i (addr_i),
    .addrOk_o (addrOk), .dataOk_o (dataOk), .rdData_o (rdData),
    .memReq_o (memReq), .memResp_i (memResp)
  );

  refillMem uMem (
    .clk (clk), .rst_n (rst_n), .memReq_i (memReq), .gap_i (gap), .memResp_o (memResp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // taps 16 14 13 11 with the new bit entering at the bottom
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [7:0] randBits(input int n);
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      addrLfsr = lfsrStep(addrLfsr);
      r = {r[6:0], addrLfsr[0]};
    end
    return r;
  endfunction

  function automatic word_t expectedWord(input addr_t a);
    addr_t w;
    w = {a[31:3], 3'b000};
    return {~w, w};
  endfunction

  // predicts hit or miss and updates the way state like the cache does
  function automatic logic lookupRef(input addr_t a);
    tagEntry_t          tg;
    logic [INDEX_W-1:0] ix;
    logic               vic;
    tg = a[31:11];
    ix = a[10:5];
    if (vldRef[ix][0] && tagRef[ix][0] == tg) begin
      lruRef[ix] = 1'b1;
      return 1'b1;
    end
    if (vldRef[ix][1] && tagRef[ix][1] == tg) begin
      lruRef[ix] = 1'b0;
      return 1'b1;
    end
    vic = !vldRef[ix][0] ? 1'b0 : !vldRef[ix][1] ? 1'b1 : lruRef[ix];
    vldRef[ix][vic] = 1'b1;
    tagRef[ix][vic] = tg;
    lruRef[ix] = ~vic;
    return 1'b0;
  endfunction

  task automatic reportMismatch(input string what, input logic [63:0] expv,
                                input logic [63:0] actv);
    $display("ERROR %s %s: expected %h, actual %h", testName, what, expv, actv);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic reportProblem(input string msg);
    $display("%s during %s", msg, testName);
    $display("Verification failed");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle > CYCLE_LIMIT) begin
      $display("timeout, the run went past %0d cycles", CYCLE_LIMIT);
      $display("Verification failed");
      $fatal(1);
    end
  end

  // two lfsr bits per cycle for the beat gap
  always @(posedge clk) begin
    gapLfsr = lfsrStep(gapLfsr);
    gap[1] <= gapLfsr[0];
    gapLfsr = lfsrStep(gapLfsr);
    gap[0] <= gapLfsr[0];
  end

  always @(posedge clk) begin : monitorBlk
    word_t exp;
    if (rst_n) begin
      if (memReq.valid) begin
        assert (pending.size() == 1 && !predHit[0])
          else reportProblem("line request without a predicted miss");
        assert (memReq.addr == {pending[0][31:5], 5'b0})
          else reportMismatch("line address", 64'({pending[0][31:5], 5'b0}),
                              64'(memReq.addr));
        reqSeen++;
      end
      if (dataOk) begin
        assert (pending.size() > 0) else reportProblem("answer without a request");
        exp = expectedWord(pending[0]);
        assert (rdData == exp) else reportMismatch("read data", exp, rdData);
        assert (reqSeen == (predHit[0] ? 0 : 1))
          else reportMismatch("line requests", predHit[0] ? 64'd0 : 64'd1, 64'(reqSeen));
        if (predHit[0]) begin
          assert (cycle == acceptAt[0] + 1)
            else reportMismatch("hit latency", 64'(acceptAt[0] + 1), 64'(cycle));
        end
        lastMissed = (reqSeen != 0);
        void'(pending.pop_front());
        void'(predHit.pop_front());
        void'(acceptAt.pop_front());
        reqSeen = 0;
      end
      if (valid_i && addrOk) begin
        lastPredHit = lookupRef(addr_i);
        pending.push_back(addr_i);
        predHit.push_back(lastPredHit);
        acceptAt.push_back(cycle);
      end
    end
  end

  // returns at the edge where the request is taken
  task automatic sendReq(input addr_t a);
    valid_i <= 1'b1;
    addr_i  <= a;
    @(posedge clk);
    while (!addrOk) begin
      @(posedge clk);
    end
  endtask

  task automatic waitIdle();
    do begin
      @(posedge clk);
    end while (pending.size() != 0);
    @(posedge clk);
  endtask

  task automatic access(input addr_t a);
    sendReq(a);
    valid_i <= 1'b0;
    waitIdle();
  endtask

  function automatic addr_t setAddr(input int tg, input int ix);
    return {21'(tg), 6'(ix), 5'd0};
  endfunction

  initial begin : stimulus
    int         c0;
    logic [7:0] tg;
    logic [7:0] ix;
    logic [7:0] w;
    rst_n   = 1'b0;
    valid_i = 1'b0;
    addr_i  = '0;
    gap     = '0;
    for (int i = 0; i < SETS; i++) begin
      vldRef[i] = 2'b00;
      lruRef[i] = 1'b0;
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    assert (addrOk == 1'b1) else reportMismatch("addrOk", 64'd1, 64'(addrOk));
    assert (dataOk == 1'b0) else reportMismatch("dataOk", 64'd0, 64'(dataOk));
    assert (memReq.valid == 1'b0) else reportMismatch("memReq", 64'd0, 64'(memReq.valid));

    testName = "cold miss";
    access(32'h0000_1008);
    access(32'h0004_2230);

    testName = "repeated access";
    for (int i = 0; i < 4; i++) begin
      access(32'h0000_1000 + 32'(i * 8));
    end

    testName = "back-to-back hits";
    sendReq(32'h0000_1000);
    c0 = cycle;
    sendReq(32'h0000_1010);
    sendReq(32'h0000_1018);
    sendReq(32'h0004_2238);
    assert (cycle - c0 == 3) else reportMismatch("accept cycles", 64'd3, 64'(cycle - c0));
    valid_i <= 1'b0;
    waitIdle();

    // A B A B A then C must evict B
    testName = "two ways and lru";
    access(setAddr(1, 9));
    access(setAddr(2, 9));
    access(setAddr(1, 9));
    assert (!lastMissed) else reportProblem("way A was not resident");
    access(setAddr(2, 9));
    assert (!lastMissed) else reportProblem("way B was not resident");
    access(setAddr(1, 9));
    access(setAddr(3, 9));
    access(setAddr(1, 9));
    assert (!lastMissed) else reportProblem("line A was evicted");
    access(setAddr(2, 9));
    assert (lastMissed) else reportProblem("line B was not evicted");

    testName = "random mix";
    for (int i = 0; i < RAND_REQ; i++) begin
      tg = randBits(3);
      ix = randBits(2);
      w  = randBits(2);
      sendReq({18'd0, tg[2:0], 4'd0, ix[1:0], w[1:0], 3'd0});
      if (randBits(1) == 8'd1) begin
        valid_i <= 1'b0;
        waitIdle();
      end
    end
    valid_i <= 1'b0;
    waitIdle();

    $display("Verification passed");
    $finish;
  end

endmodule

/* list.f */
rtl/cachePkg.sv
rtl/cacheSram.sv
rtl/refillBuffer.sv
rtl/wayStateTable.sv
rtl/cacheCtrl.sv
rtl/icacheTop.sv
test/refillMem.sv
test/cacheCtrl_props.sv
test/cacheTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cacheTb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
